//--- reg_axi_pkg.sv
// Register-bus to AXI4 subsystem package
// Holds bus widths, memory size, AXI encodings and all channel structs
package reg_axi_pkg;

  // Register bus and AXI share one address and data width
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // AXI ID and user widths; the adapter always drives zero on both
  localparam int unsigned AXI_ID_W   = 4;
  localparam int unsigned AXI_USER_W = 1;

  // Memory slave depth in 32-bit words
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);
  // First byte address that lies outside the memory
  localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_WORDS * 4);

  // Size code for one full-width beat of four bytes
  localparam logic [2:0] AXI_SIZE   = 3'd2;
  localparam logic [1:0] BURST_INCR = 2'b01;
  // Modifiable, non-bufferable, non-allocating
  localparam logic [3:0] AXI_CACHE  = 4'b0010;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Single-word register bus request from the master
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              valid;
  } reg_req_t;

  // Register bus response; rdata and error only count while ready is high
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
    logic              ready;
  } reg_rsp_t;

  // Shared AR and AW payload
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [ADDR_W-1:0]     addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [3:0]            cache;
    logic [AXI_USER_W-1:0] user;
  } axi_ax_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
    logic [1:0]          resp;
    logic                last;
  } axi_r_t;

  // Everything the AXI master drives
  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Everything the AXI slave drives
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
  } axi_rsp_t;

endpackage

//--- axi_chan_reg.sv
// One-entry valid/ready register slice for a single AXI channel
// The payload type is a parameter so AR, AW and W share this block
module axi_chan_reg #(
  parameter type chan_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  chan_t data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output chan_t data_o
);

  logic  full_q;
  chan_t data_q;
  logic  load;

  // Accept when empty, or when the stored item leaves in this same cycle,
  // which keeps a throughput of one item per cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  // Full flag tracks whether the stage holds an item
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload only moves on an input transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  // Output valid comes from a flop and never looks at ready_i
  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

//--- axi_from_reg.sv
// Register bus to AXI4 adapter
// Issues one single-beat AXI transaction per request and blocks until B or R returns
module axi_from_reg
  import reg_axi_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output axi_req_t axi_req_o,
  input  axi_rsp_t axi_rsp_i
);

  // One flag per request channel, set once that channel has handed off
  // the held request, so the same request is never issued twice
  logic ar_pending_q;
  logic aw_pending_q;
  logic w_pending_q;

  logic rd_req;
  logic wr_req;

  // The master holds the request stable, so the payloads come straight from it
  assign rd_req = reg_req_i.valid & ~reg_req_i.write;
  assign wr_req = reg_req_i.valid & reg_req_i.write;

  // A response clears the flag and wins over a handshake in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ar_pending_q <= 1'b0;
      aw_pending_q <= 1'b0;
      w_pending_q  <= 1'b0;
    end else begin
      if (axi_rsp_i.r_valid) begin
        ar_pending_q <= 1'b0;
      end else if (axi_req_o.ar_valid && axi_rsp_i.ar_ready) begin
        ar_pending_q <= 1'b1;
      end
      if (axi_rsp_i.b_valid) begin
        aw_pending_q <= 1'b0;
      end else if (axi_req_o.aw_valid && axi_rsp_i.aw_ready) begin
        aw_pending_q <= 1'b1;
      end
      if (axi_rsp_i.b_valid) begin
        w_pending_q <= 1'b0;
      end else if (axi_req_o.w_valid && axi_rsp_i.w_ready) begin
        w_pending_q <= 1'b1;
      end
    end
  end

  // Read address channel
  assign axi_req_o.ar = '{
    id:    '0,
    addr:  reg_req_i.addr,
    len:   8'd0,
    size:  AXI_SIZE,
    burst: BURST_INCR,
    cache: AXI_CACHE,
    user:  '0
  };
  assign axi_req_o.ar_valid = rd_req & ~ar_pending_q;
  // Never back-pressure R while a read is held
  assign axi_req_o.r_ready  = rd_req;

  // Write address channel
  assign axi_req_o.aw = '{
    id:    '0,
    addr:  reg_req_i.addr,
    len:   8'd0,
    size:  AXI_SIZE,
    burst: BURST_INCR,
    cache: AXI_CACHE,
    user:  '0
  };
  assign axi_req_o.aw_valid = wr_req & ~aw_pending_q;
  assign axi_req_o.b_ready  = wr_req;

  // Write data goes out alongside AW; each side tracks its own handoff
  assign axi_req_o.w = '{
    data: reg_req_i.wdata,
    strb: reg_req_i.wstrb,
    last: 1'b1
  };
  assign axi_req_o.w_valid = wr_req & ~w_pending_q;

  // Response pulse lasts exactly the one cycle of the B or R transfer
  assign reg_rsp_o.ready = axi_rsp_i.r_valid | axi_rsp_i.b_valid;
  assign reg_rsp_o.rdata = axi_rsp_i.r.data;
  // Anything other than OKAY is reported as an error
  assign reg_rsp_o.error = reg_req_i.write ? (axi_rsp_i.b.resp != RESP_OKAY)
                                           : (axi_rsp_i.r.resp != RESP_OKAY);

endmodule

//--- axi_mem_slave.sv
// AXI4 single-beat memory slave with byte strobes
// Out-of-range accesses return SLVERR; writes there are dropped, reads give zero
module axi_mem_slave
  import reg_axi_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  // Read address
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  axi_ax_t ar_i,
  // Write address
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_ax_t aw_i,
  // Write data
  input  logic    w_valid_i,
  output logic    w_ready_o,
  input  axi_w_t  w_i,
  // Write response
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output axi_b_t  b_o,
  // Read data
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output axi_r_t  r_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // AW and W may arrive in either order, so each has its own holding register
  logic    aw_held_q;
  logic    w_held_q;
  axi_ax_t aw_q;
  axi_w_t  w_q;

  logic                b_valid_q;
  logic [1:0]          b_resp_q;
  logic [AXI_ID_W-1:0] b_id_q;

  logic                r_valid_q;
  logic [DATA_W-1:0]   r_data_q;
  logic [1:0]          r_resp_q;
  logic [AXI_ID_W-1:0] r_id_q;

  logic    aw_hs;
  logic    w_hs;
  logic    ar_hs;
  logic    do_write;
  axi_ax_t aw_cur;
  axi_w_t  w_cur;
  logic    wr_in_range;
  logic    rd_in_range;

  // No new request is taken while its response is still waiting
  assign ar_ready_o = ~r_valid_q;
  assign aw_ready_o = ~aw_held_q & ~b_valid_q;
  assign w_ready_o  = ~w_held_q & ~b_valid_q;

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  assign ar_hs = ar_valid_i & ar_ready_o;

  // Use the held copy if present, else the beat arriving now, so the write
  // happens in the cycle the second half shows up
  assign aw_cur   = aw_held_q ? aw_q : aw_i;
  assign w_cur    = w_held_q ? w_q : w_i;
  assign do_write = (aw_held_q | aw_hs) & (w_held_q | w_hs);

  assign wr_in_range = aw_cur.addr < MEM_BYTES;
  assign rd_in_range = ar_i.addr < MEM_BYTES;

  // Control state for holding registers and response valids
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (do_write) begin
        aw_held_q <= 1'b0;
        w_held_q  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_held_q <= 1'b1;
        end
        if (w_hs) begin
          w_held_q <= 1'b1;
        end
      end
      if (do_write) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (ar_hs) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Payloads, response fields and the memory array itself
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q <= aw_i;
    end
    if (w_hs) begin
      w_q <= w_i;
    end
    if (do_write) begin
      b_id_q   <= aw_cur.id;
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      if (wr_in_range) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (w_cur.strb[b]) begin
            mem_q[aw_cur.addr[MEM_IDX_W+1:2]][8*b +: 8] <= w_cur.data[8*b +: 8];
          end
        end
      end
    end
    if (ar_hs) begin
      r_id_q   <= ar_i.id;
      r_data_q <= rd_in_range ? mem_q[ar_i.addr[MEM_IDX_W+1:2]] : '0;
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_o       = '{id: b_id_q, resp: b_resp_q};

  // Every read is a single beat, so last is always set
  assign r_valid_o = r_valid_q;
  assign r_o       = '{id: r_id_q, data: r_data_q, resp: r_resp_q, last: 1'b1};

endmodule

//--- reg_axi_top.sv
// Register bus to AXI memory subsystem
// Adapter feeds AR, AW and W through register slices into a memory slave
module reg_axi_top
  import reg_axi_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o
);

  // Adapter-side AXI bundles
  axi_req_t mst_req;
  axi_rsp_t mst_rsp;

  // Slice outputs toward the memory slave
  logic    ar_valid;
  logic    ar_ready;
  axi_ax_t ar;
  logic    aw_valid;
  logic    aw_ready;
  axi_ax_t aw;
  logic    w_valid;
  logic    w_ready;
  axi_w_t  w;

  // Slice input readies back toward the adapter
  logic ar_slice_ready;
  logic aw_slice_ready;
  logic w_slice_ready;

  // B and R bypass the slices
  logic   b_valid;
  axi_b_t b;
  logic   r_valid;
  axi_r_t r;

  axi_from_reg u_axi_from_reg (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .axi_req_o (mst_req),
    .axi_rsp_i (mst_rsp)
  );

  // Repack slice readies and slave responses into the adapter's response bundle
  assign mst_rsp = '{
    aw_ready: aw_slice_ready,
    w_ready:  w_slice_ready,
    b:        b,
    b_valid:  b_valid,
    ar_ready: ar_slice_ready,
    r:        r,
    r_valid:  r_valid
  };

  axi_chan_reg #(.chan_t(axi_ax_t)) u_ar_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mst_req.ar_valid),
    .ready_o (ar_slice_ready),
    .data_i  (mst_req.ar),
    .valid_o (ar_valid),
    .ready_i (ar_ready),
    .data_o  (ar)
  );

  axi_chan_reg #(.chan_t(axi_ax_t)) u_aw_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mst_req.aw_valid),
    .ready_o (aw_slice_ready),
    .data_i  (mst_req.aw),
    .valid_o (aw_valid),
    .ready_i (aw_ready),
    .data_o  (aw)
  );

  axi_chan_reg #(.chan_t(axi_w_t)) u_w_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mst_req.w_valid),
    .ready_o (w_slice_ready),
    .data_i  (mst_req.w),
    .valid_o (w_valid),
    .ready_i (w_ready),
    .data_o  (w)
  );

  axi_mem_slave u_axi_mem_slave (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_i       (ar),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_i       (aw),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_i        (w),
    .b_valid_o  (b_valid),
    .b_ready_i  (mst_req.b_ready),
    .b_o        (b),
    .r_valid_o  (r_valid),
    .r_ready_i  (mst_req.r_ready),
    .r_o        (r)
  );

endmodule

//--- tb_reg_axi_top.sv
// Testbench for the register-bus to AXI memory subsystem
// Drives single-word requests and checks responses against a reference memory model
module tb_reg_axi_top
  import reg_axi_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int ACCESS_TIMEOUT = 100;
  localparam int RAND_OPS       = 200;
  localparam int SIM_LIMIT      = 400000;

  logic     clk_i = 1'b0;
  logic     rst_i;
  reg_req_t reg_req_i;
  reg_rsp_t reg_rsp_o;

  // Expected memory contents, indexed by word
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];

  logic [15:0] lfsr_q = 16'd38914;

  int   err_cnt        = 0;
  int   test_err_base  = 0;
  int   tests_passed   = 0;
  int   tests_failed   = 0;
  int   req_cnt        = 0;
  int   ready_cnt      = 0;
  logic req_started    = 1'b0;
  logic timed_out      = 1'b0;

  logic [31:0] addr_v;
  logic [31:0] data_v;
  logic [3:0]  strb_v;
  logic        wr_v;
  logic [31:0] addr_list [8];
  logic [3:0]  strb_list [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0101, 4'b1010, 4'b0011, 4'b1100};

  reg_axi_top u_reg_axi_top (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o)
  );

  always #4 clk_i = ~clk_i;

  // 16-bit Galois LFSR with taps at 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Fill value mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic in_range(input logic [31:0] addr);
    return addr < MEM_BYTES;
  endfunction

  // Strobed bytes come from the new word, the rest keep the old value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return m;
  endfunction

  // Out-of-range reads return zero data
  function automatic logic [31:0] exp_read(input logic [31:0] addr);
    if (in_range(addr)) begin
      return ref_mem[addr[MEM_IDX_W+1:2]];
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] obs,
                             input logic [31:0] exp);
    assert (obs === exp) else begin
      $display("Error at %0t: %s expected %h observed %h", $time, name, exp, obs);
      err_cnt++;
    end
  endtask

  // Print one line for the finished test and start a fresh error window
  task automatic test_end(input string name);
    int errs;
    errs = err_cnt - test_err_base;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("%s finished with %0d errors", name, errs);
    test_err_base = err_cnt;
  endtask

  // Present one request, wait for its ready pulse and check the response.
  // With drop_valid low the next request may follow in the very next cycle
  task automatic reg_access(input logic        write,
                            input logic [31:0] addr,
                            input logic [31:0] wdata,
                            input logic [3:0]  wstrb,
                            input logic [31:0] exp_rdata,
                            input logic        check_rdata,
                            input logic        exp_error,
                            input logic        drop_valid);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    // A stuck bus makes every later request meaningless
    if (timed_out) return;
    @(posedge clk_i);
    req_started = 1'b1;
    req_cnt++;
    reg_req_i <= '{addr: addr, write: write, wdata: wdata, wstrb: wstrb, valid: 1'b1};
    // Sample at the falling edge, away from the clock edge that moves the DUT
    while (!got && cycles < ACCESS_TIMEOUT) begin
      @(negedge clk_i);
      if (reg_rsp_o.ready) begin
        got = 1'b1;
        check_value("reg_rsp_o.error", 32'(reg_rsp_o.error), 32'(exp_error));
        if (check_rdata) begin
          check_value("reg_rsp_o.rdata", reg_rsp_o.rdata, exp_rdata);
        end
      end else begin
        cycles++;
      end
    end
    if (!got) begin
      $display("Timeout at %0t: no ready pulse within %0d cycles for the %s at address %h",
               $time, ACCESS_TIMEOUT, write ? "write" : "read", addr);
      err_cnt++;
      timed_out = 1'b1;
    end
    if (!got || drop_valid) begin
      @(posedge clk_i);
      reg_req_i.valid <= 1'b0;
    end
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input logic drop);
    reg_access(1'b1, addr, data, strb, '0, 1'b0, !in_range(addr), drop);
    if (in_range(addr)) begin
      ref_mem[addr[MEM_IDX_W+1:2]] = merge_bytes(ref_mem[addr[MEM_IDX_W+1:2]], data, strb);
    end
  endtask

  task automatic do_read(input logic [31:0] addr, input logic drop);
    reg_access(1'b0, addr, '0, '0, exp_read(addr), 1'b1, !in_range(addr), drop);
  endtask

  // Ready must stay low until the first request, and every pulse is counted
  always @(negedge clk_i) begin
    if (!req_started) begin
      check_value("reg_rsp_o.ready", 32'(reg_rsp_o.ready), 32'd0);
    end
    if (reg_rsp_o.ready) begin
      ready_cnt++;
    end
  end

  initial begin
    #(SIM_LIMIT);
    $display("Simulation time limit reached before the test sequence ended");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rst_i     <= 1'b1;
    reg_req_i <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    test_end("reset_quiet");

    // Give every word a known value so later reads have a defined answer
    for (int i = 0; i < int'(MEM_WORDS); i++) begin
      do_write(32'(i * 4), fill_word(32'(i * 4)), 4'hF, i == int'(MEM_WORDS) - 1);
    end
    test_end("memory_fill");

    for (int i = 0; i < 8; i++) begin
      addr_list[i] = rand_bits(8) << 2;
      do_write(addr_list[i], rand_bits(32), 4'hF, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      do_read(addr_list[i], i == 7);
    end
    test_end("write_read");

    for (int i = 0; i < 8; i++) begin
      addr_v = rand_bits(8) << 2;
      do_write(addr_v, rand_bits(32), strb_list[i], 1'b0);
      do_read(addr_v, i == 7);
    end
    test_end("byte_strobes");

    // Out-of-range writes alias words 0 and 255 in the low address bits
    do_write(MEM_BYTES, 32'hDEAD_BEEF, 4'hF, 1'b0);
    do_write(32'hFFFF_FFFC, 32'hCAFE_F00D, 4'hF, 1'b0);
    do_read(32'h0000_0000, 1'b0);
    do_read(MEM_BYTES - 32'd4, 1'b0);
    do_read(MEM_BYTES, 1'b0);
    do_read(32'h8000_0000, 1'b1);
    test_end("out_of_range");

    // Back-to-back mix with roughly one access in eight out of range
    for (int n = 0; n < RAND_OPS; n++) begin
      wr_v = rand_bits(1) == 32'd1;
      if (rand_bits(3) == 32'd0) begin
        addr_v = MEM_BYTES + (rand_bits(20) << 2);
      end else begin
        addr_v = rand_bits(8) << 2;
      end
      if (wr_v) begin
        data_v = rand_bits(32);
        strb_v = 4'(rand_bits(4));
        do_write(addr_v, data_v, strb_v, n == RAND_OPS - 1);
      end else begin
        do_read(addr_v, n == RAND_OPS - 1);
      end
    end
    // Let any stray pulse show up before counting
    repeat (8) @(posedge clk_i);
    check_value("ready pulse count", 32'(ready_cnt), 32'(req_cnt));
    test_end("random_back_to_back");

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
reg_axi_pkg.sv
axi_chan_reg.sv
axi_from_reg.sv
axi_mem_slave.sv
reg_axi_top.sv
tb_reg_axi_top.sv

//--- Makefile
# Verilator build and run for the register-bus to AXI subsystem

VERILATOR ?= verilator
TOP       ?= tb_reg_axi_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASS

SRCS := $(wildcard *.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
